//--- source/alloc_word_pkg.sv
// tagged cell word definitions
package alloc_word_pkg;

    typedef logic [15:0] cell_word_t;

    // fixnum view, flag set
    typedef struct packed {
        logic        fix;
        logic [14:0] value;
    } fixnum_view_t;

    // reference view, flag clear
    typedef struct packed {
        logic        fix;
        logic [2:0]  region;
        logic [11:0] offset;
    } ptr_view_t;

    typedef union packed {
        fixnum_view_t fixnum;
        ptr_view_t    ptr;
        cell_word_t   raw;
    } cell_word_u;

    // region 0 holds the reserved words
    localparam cell_word_t UNDEF     = 16'h0000;
    localparam cell_word_t NIL       = 16'h0001;
    localparam cell_word_t TRUE      = 16'h0002;
    localparam cell_word_t FALSE     = 16'h0003;
    localparam cell_word_t UNIT      = 16'h0004;
    localparam cell_word_t ZERO      = 16'h8000;
    localparam cell_word_t HEAP_BASE = 16'h5000;

    localparam logic [2:0] HEAP_REGION = 3'd5;

    function automatic cell_word_t make_fixnum(input logic [14:0] value);
        cell_word_u w;
        w.fixnum.fix   = 1'b1;
        w.fixnum.value = value;
        return w.raw;
    endfunction

    function automatic cell_word_t make_ref(input logic [11:0] offset);
        cell_word_u w;
        w.ptr.fix    = 1'b0;
        w.ptr.region = HEAP_REGION;
        w.ptr.offset = offset;
        return w.raw;
    endfunction

endpackage

//--- source/alloc_port_pkg.sv
// allocator port structs
package alloc_port_pkg;

    // allocate one cell holding data
    typedef struct packed {
        logic                       en;
        alloc_word_pkg::cell_word_t data;
    } alloc_req_t;

    // return a cell to the free list
    typedef struct packed {
        logic                       en;
        alloc_word_pkg::cell_word_t addr;
    } free_req_t;

    typedef struct packed {
        logic                       en;
        alloc_word_pkg::cell_word_t addr;
        alloc_word_pkg::cell_word_t data;
    } wr_req_t;

    typedef struct packed {
        logic                       en;
        alloc_word_pkg::cell_word_t addr;
    } rd_req_t;

    // both fields hold until their next request
    typedef struct packed {
        alloc_word_pkg::cell_word_t aaddr;
        alloc_word_pkg::cell_word_t rdata;
    } alloc_rsp_t;

endpackage

//--- source/cell_ram.sv
// heap cell memory
module cell_ram #(
    parameter int CELL_ADDR_W = 8
) (
    input  logic                       i_clk,
    input  logic                       i_wr_en,
    input  logic [CELL_ADDR_W-1:0]     i_wr_offset,
    input  alloc_word_pkg::cell_word_t i_wr_data,
    input  logic                       i_rd_en,
    input  logic [CELL_ADDR_W-1:0]     i_rd_offset,
    output alloc_word_pkg::cell_word_t o_rd_data
);
    import alloc_word_pkg::*;

    localparam int DEPTH = 2 ** CELL_ADDR_W;

    cell_word_t mem [DEPTH];

    // nonblocking read sees the contents before this edge's write
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_offset] <= i_wr_data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_offset];
        end
    end

endmodule

//--- source/free_list.sv
// free cell list with bump pointer
module free_list #(
    parameter int CELL_ADDR_W = 8
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_take,
    input  logic                   i_give,
    input  logic [CELL_ADDR_W-1:0] i_give_offset,
    output logic [CELL_ADDR_W-1:0] o_next_offset,
    output logic                   o_empty
);
    localparam int DEPTH = 2 ** CELL_ADDR_W;

    // list entry, valid clear marks the tail
    typedef struct packed {
        logic                   valid;
        logic [CELL_ADDR_W-1:0] offset;
    } link_t;

    link_t                head;
    link_t                link_mem [DEPTH];
    // extra top bit set once every cell was handed out
    logic [CELL_ADDR_W:0] bump;
    logic                 push;
    logic                 pop;

    // give and take together pass the cell straight through
    assign push = i_give && !i_take;
    assign pop  = i_take && !i_give;

    assign o_next_offset = head.valid ? head.offset : bump[CELL_ADDR_W-1:0];
    assign o_empty       = !head.valid && bump[CELL_ADDR_W];

    // freed cell remembers the old head
    always_ff @(posedge i_clk) begin
        if (push) begin
            link_mem[i_give_offset] <= head;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            head <= '0;
            bump <= '0;
        end else if (push) begin
            head.valid  <= 1'b1;
            head.offset <= i_give_offset;
        end else if (pop) begin
            if (head.valid) begin
                head <= link_mem[head.offset];
            end else if (!bump[CELL_ADDR_W]) begin
                bump <= bump + 1'b1;
            end
        end
    end

endmodule

//--- source/linked_alloc.sv
// linked-memory allocator
module linked_alloc #(
    parameter int CELL_ADDR_W = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  alloc_port_pkg::alloc_req_t i_alloc,
    input  alloc_port_pkg::free_req_t  i_free,
    input  alloc_port_pkg::wr_req_t    i_wr,
    input  alloc_port_pkg::rd_req_t    i_rd,
    output alloc_port_pkg::alloc_rsp_t o_rsp
);
    import alloc_word_pkg::*;

    cell_word_u             free_ref;
    cell_word_u             wr_ref;
    cell_word_u             rd_ref;
    logic [CELL_ADDR_W-1:0] next_offset;
    logic [CELL_ADDR_W-1:0] alloc_offset;
    logic                   empty;
    logic                   alloc_ok;
    logic                   ram_we;
    logic [CELL_ADDR_W-1:0] ram_wr_offset;
    cell_word_t             ram_wr_data;
    cell_word_t             ram_rd_data;
    cell_word_t             aaddr_q;
    logic                   rd_seen;

    assign free_ref = i_free.addr;
    assign wr_ref   = i_wr.addr;
    assign rd_ref   = i_rd.addr;

    // a concurrent free hands its cell straight to the alloc
    assign alloc_ok     = i_alloc.en && (i_free.en || !empty);
    assign alloc_offset = i_free.en ? free_ref.ptr.offset[CELL_ADDR_W-1:0] : next_offset;

    // alloc owns the single write port over a plain write
    assign ram_we        = alloc_ok || i_wr.en;
    assign ram_wr_offset = alloc_ok ? alloc_offset : wr_ref.ptr.offset[CELL_ADDR_W-1:0];
    assign ram_wr_data   = alloc_ok ? i_alloc.data : i_wr.data;

    free_list #(
        .CELL_ADDR_W(CELL_ADDR_W)
    ) u_free_list (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_take       (alloc_ok),
        .i_give       (i_free.en),
        .i_give_offset(free_ref.ptr.offset[CELL_ADDR_W-1:0]),
        .o_next_offset(next_offset),
        .o_empty      (empty)
    );

    cell_ram #(
        .CELL_ADDR_W(CELL_ADDR_W)
    ) u_cell_ram (
        .i_clk      (i_clk),
        .i_wr_en    (ram_we),
        .i_wr_offset(ram_wr_offset),
        .i_wr_data  (ram_wr_data),
        .i_rd_en    (i_rd.en),
        .i_rd_offset(rd_ref.ptr.offset[CELL_ADDR_W-1:0]),
        .o_rd_data  (ram_rd_data)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            aaddr_q <= UNDEF;
            rd_seen <= 1'b0;
        end else begin
            if (i_alloc.en) begin
                aaddr_q <= alloc_ok ? make_ref(12'(alloc_offset)) : UNDEF;
            end
            if (i_rd.en) begin
                rd_seen <= 1'b1;
            end
        end
    end

    assign o_rsp.aaddr = aaddr_q;
    // no read since reset reports UNDEF
    assign o_rsp.rdata = rd_seen ? ram_rd_data : UNDEF;

endmodule

//--- source/alloc_self_test.sv
// allocator built-in self-test
module alloc_self_test (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,
    input  alloc_port_pkg::alloc_req_t i_alloc,
    input  alloc_port_pkg::free_req_t  i_free,
    input  alloc_port_pkg::wr_req_t    i_wr,
    input  alloc_port_pkg::rd_req_t    i_rd,
    input  alloc_port_pkg::alloc_rsp_t i_rsp,
    output alloc_port_pkg::alloc_req_t o_alloc,
    output alloc_port_pkg::free_req_t  o_free,
    output alloc_port_pkg::wr_req_t    o_wr,
    output alloc_port_pkg::rd_req_t    o_rd,
    output logic                       o_running,
    output logic                       o_passed,
    output alloc_word_pkg::cell_word_t o_debug
);
    import alloc_word_pkg::*;
    import alloc_port_pkg::*;

    localparam logic [4:0] LAST_STEP = 5'd20;

    // expected word for the result of the previous step
    typedef struct packed {
        logic       en;
        logic       on_aaddr;
        cell_word_t word;
    } check_t;

    logic [4:0] step;
    alloc_req_t s_alloc;
    free_req_t  s_free;
    wr_req_t    s_wr;
    rd_req_t    s_rd;
    check_t     chk;
    cell_word_t got;

    assign o_running = i_en && (step != 5'd0);

    assign o_alloc = o_running ? s_alloc : i_alloc;
    assign o_free  = o_running ? s_free : i_free;
    assign o_wr    = o_running ? s_wr : i_wr;
    assign o_rd    = o_running ? s_rd : i_rd;

    assign got = chk.on_aaddr ? i_rsp.aaddr : i_rsp.rdata;

    // the script
    always_comb begin
        s_alloc = '0;
        s_free  = '0;
        s_wr    = '0;
        s_rd    = '0;
        chk     = '0;
        case (step)
            5'd2: s_wr = '{1'b1, make_ref(12'd42), make_fixnum(15'd420)};
            5'd3: s_wr = '{1'b1, make_ref(12'd144), make_fixnum(15'd1337)};
            5'd4: s_rd = '{1'b1, make_ref(12'd42)};
            5'd5: begin
                chk  = '{1'b1, 1'b0, make_fixnum(15'd420)};
                s_rd = '{1'b1, make_ref(12'd144)};
            end
            5'd6: chk = '{1'b1, 1'b0, make_fixnum(15'd1337)};
            // read and write in one cycle, reads see the old word
            5'd7: begin
                s_rd = '{1'b1, make_ref(12'd42)};
                s_wr = '{1'b1, make_ref(12'd34), make_fixnum(15'd55)};
            end
            5'd8: begin
                chk  = '{1'b1, 1'b0, make_fixnum(15'd420)};
                s_rd = '{1'b1, make_ref(12'd144)};
                s_wr = '{1'b1, make_ref(12'd144), make_fixnum(15'd360)};
            end
            5'd9:  chk = '{1'b1, 1'b0, make_fixnum(15'd1337)};
            5'd10: s_alloc = '{1'b1, make_fixnum(15'd256)};
            5'd11: begin
                chk     = '{1'b1, 1'b1, make_ref(12'd0)};
                s_alloc = '{1'b1, make_fixnum(15'd257)};
            end
            5'd12: begin
                chk     = '{1'b1, 1'b1, make_ref(12'd1)};
                s_alloc = '{1'b1, make_fixnum(15'd258)};
            end
            5'd13: chk = '{1'b1, 1'b1, make_ref(12'd2)};
            5'd14: s_free = '{1'b1, make_ref(12'd2)};
            5'd15: s_free = '{1'b1, make_ref(12'd1)};
            5'd16: s_alloc = '{1'b1, make_fixnum(15'd259)};
            // free and alloc together
            5'd17: begin
                chk     = '{1'b1, 1'b1, make_ref(12'd1)};
                s_free  = '{1'b1, make_ref(12'd0)};
                s_alloc = '{1'b1, make_fixnum(15'd260)};
            end
            5'd18: begin
                chk     = '{1'b1, 1'b1, make_ref(12'd0)};
                s_alloc = '{1'b1, make_fixnum(15'd261)};
            end
            5'd19: chk = '{1'b1, 1'b1, make_ref(12'd2)};
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            step     <= 5'd1;
            o_passed <= 1'b0;
            o_debug  <= UNDEF;
        end else if (o_running) begin
            if (chk.en && (got != chk.word)) begin
                // keep the wrong word and stop
                o_debug <= got;
                step    <= 5'd0;
            end else if (step == LAST_STEP) begin
                o_passed <= 1'b1;
                step     <= 5'd0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

//--- source/alloc_top.sv
// allocator with self-test
module alloc_top #(
    parameter int CELL_ADDR_W = 8
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,
    input  alloc_port_pkg::alloc_req_t i_alloc,
    input  alloc_port_pkg::free_req_t  i_free,
    input  alloc_port_pkg::wr_req_t    i_wr,
    input  alloc_port_pkg::rd_req_t    i_rd,
    output alloc_port_pkg::alloc_rsp_t o_rsp,
    output logic                       o_running,
    output logic                       o_passed,
    output alloc_word_pkg::cell_word_t o_debug
);
    import alloc_port_pkg::*;

    alloc_req_t la_alloc;
    free_req_t  la_free;
    wr_req_t    la_wr;
    rd_req_t    la_rd;

    // self-test muxes its script over the outside requests
    alloc_self_test u_self_test (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_en     (i_en),
        .i_alloc  (i_alloc),
        .i_free   (i_free),
        .i_wr     (i_wr),
        .i_rd     (i_rd),
        .i_rsp    (o_rsp),
        .o_alloc  (la_alloc),
        .o_free   (la_free),
        .o_wr     (la_wr),
        .o_rd     (la_rd),
        .o_running(o_running),
        .o_passed (o_passed),
        .o_debug  (o_debug)
    );

    linked_alloc #(
        .CELL_ADDR_W(CELL_ADDR_W)
    ) u_linked_alloc (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_alloc(la_alloc),
        .i_free (la_free),
        .i_wr   (la_wr),
        .i_rd   (la_rd),
        .o_rsp  (o_rsp)
    );

endmodule

//--- testbench/alloc_top_tb.sv
// allocator testbench
module alloc_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import alloc_word_pkg::*;
    import alloc_port_pkg::*;

    // small heap so that the fill test stays short
    localparam int CELL_ADDR_W  = 3;
    localparam int PAUSE_AT     = 6;
    localparam int RUN_TIMEOUT  = 40;

    typedef struct packed {
        logic       passed;
        cell_word_t debug;
    } selftest_result_t;

    logic       clk;
    logic       rst_n;
    logic       en;
    alloc_req_t alloc_req;
    free_req_t  free_req;
    wr_req_t    wr_req;
    rd_req_t    rd_req;
    alloc_rsp_t rsp;
    logic       running;
    logic       passed;
    cell_word_t debug;

    int err_count;

    alloc_top #(
        .CELL_ADDR_W(CELL_ADDR_W)
    ) i_alloc_top (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_en     (en),
        .i_alloc  (alloc_req),
        .i_free   (free_req),
        .i_wr     (wr_req),
        .i_rd     (rd_req),
        .o_rsp    (rsp),
        .o_running(running),
        .o_passed (passed),
        .o_debug  (debug)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_word(input string name, input cell_word_t got, input cell_word_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%04h expected 0x%04h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_selftest(input selftest_result_t got, input selftest_result_t exp);
        if (got.passed !== exp.passed) begin
            $display("ERR o_passed got 0x%0h expected 0x%0h", got.passed, exp.passed);
            err_count++;
        end
        if (got.debug !== exp.debug) begin
            $display("ERR o_debug got 0x%04h expected 0x%04h", got.debug, exp.debug);
            err_count++;
        end
    endtask

    task automatic apply_reset();
        en = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // one strobe cycle, then sample at the following falling edge
    task automatic run_cycle(input alloc_req_t a, input free_req_t f,
                             input wr_req_t w, input rd_req_t r);
        @(negedge clk);
        alloc_req = a;
        free_req  = f;
        wr_req    = w;
        rd_req    = r;
        @(negedge clk);
        alloc_req = '0;
        free_req  = '0;
        wr_req    = '0;
        rd_req    = '0;
    endtask

    task automatic run_selftest(input int pause, input selftest_result_t exp);
        int cycles;
        int limit;
        selftest_result_t got;
        cycles = 0;
        limit  = RUN_TIMEOUT + pause;
        apply_reset();
        en = 1'b1;
        if (pause > 0) begin
            repeat (PAUSE_AT) @(negedge clk);
            en = 1'b0;
            repeat (pause) @(negedge clk);
            // a paused self-test hands the ports back
            check_flag("o_running", running, 1'b0);
            en = 1'b1;
        end
        // o_running follows i_en, so look one edge later
        @(negedge clk);
        cycles = 1;
        while (running && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (running) begin
            $display("self-test still running after %0d cycles", limit);
            err_count++;
        end else begin
            got.passed = passed;
            got.debug  = debug;
            check_selftest(got, exp);
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               test_num;
        int               tests_failed;
        int               errs_before;
        string            line;
        logic [8*12-1:0]  op;
        logic [15:0]      a;
        logic [15:0]      b;
        logic [15:0]      exp;
        selftest_result_t st_exp;

        rst_n        = 1'b0;
        en           = 1'b0;
        alloc_req    = '0;
        free_req     = '0;
        wr_req       = '0;
        rd_req       = '0;
        err_count    = 0;
        test_num     = 0;
        tests_failed = 0;

        apply_reset();
        fd = $fopen("testbench/alloc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file testbench/alloc_tests.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h", op, a, b, exp);
                    if (n == 4) begin
                        test_num++;
                        errs_before = err_count;
                        case (op)
                            "write": begin
                                run_cycle('0, '0, '{1'b1, a, b}, '0);
                            end
                            "read": begin
                                run_cycle('0, '0, '0, '{1'b1, a});
                                check_word("o_rsp.rdata", rsp.rdata, exp);
                            end
                            "rdwr": begin
                                run_cycle('0, '0, '{1'b1, a, b}, '{1'b1, a});
                                check_word("o_rsp.rdata", rsp.rdata, exp);
                            end
                            "alloc": begin
                                run_cycle('{1'b1, b}, '0, '0, '0);
                                check_word("o_rsp.aaddr", rsp.aaddr, exp);
                            end
                            "free": begin
                                run_cycle('0, '{1'b1, a}, '0, '0);
                            end
                            "freealloc": begin
                                run_cycle('{1'b1, b}, '{1'b1, a}, '0, '0);
                                check_word("o_rsp.aaddr", rsp.aaddr, exp);
                            end
                            "selftest": begin
                                st_exp.passed = b[0];
                                st_exp.debug  = exp;
                                run_selftest(int'(a), st_exp);
                            end
                            default: begin
                                $display("unknown operation %0s in the test file", op);
                                err_count++;
                            end
                        endcase
                        if (err_count == errs_before) begin
                            $display("test %0d %0s ok", test_num, op);
                        end else begin
                            $display("test %0d %0s failed", test_num, op);
                            tests_failed++;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, err_count);
        if (err_count == 0 && test_num > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- testbench/alloc_tests.txt
# columns: operation, reference or pause cycles, datum or passed flag, expected word (hex)
# operations: write read rdwr alloc free freealloc selftest
write     5005 802a 0000
write     5006 8090 0000
read      5005 0000 802a
read      5006 0000 8090
rdwr      5005 8037 802a
read      5005 0000 8037
alloc     0000 8100 5000
alloc     0000 8101 5001
alloc     0000 8102 5002
read      5001 0000 8101
free      5002 0000 0000
free      5001 0000 0000
alloc     0000 8103 5001
alloc     0000 8104 5002
freealloc 5000 8105 5000
read      5000 0000 8105
alloc     0000 8106 5003
alloc     0000 8107 5004
alloc     0000 8108 5005
alloc     0000 8109 5006
alloc     0000 810a 5007
alloc     0000 810b 0000
read      5007 0000 810a
selftest  0000 0001 0000
selftest  0008 0001 0000

//--- tb.f
source/alloc_word_pkg.sv
source/alloc_port_pkg.sv
source/cell_ram.sv
source/free_list.sv
source/linked_alloc.sv
source/alloc_self_test.sv
source/alloc_top.sv
testbench/alloc_top_tb.sv

//--- Bender.yml
package:
  name: alloc_top

sources:
  - source/alloc_word_pkg.sv
  - source/alloc_port_pkg.sv
  - source/cell_ram.sv
  - source/free_list.sv
  - source/linked_alloc.sv
  - source/alloc_self_test.sv
  - source/alloc_top.sv
  - target: test
    files:
      - testbench/alloc_top_tb.sv
